// ==== include/sha2_config.svh ====
// ----------------------------------------------------------------------
// SHA-2 accelerator configuration
// Register port widths and the address bits that select a register
// ----------------------------------------------------------------------
`ifndef SHA2_CONFIG_SVH
`define SHA2_CONFIG_SVH

// Byte address width of the register port
`define SHA2_ADDR_W 8

// Register data width
`define SHA2_DATA_W 32

// Address bits that pick one of eight 32-bit registers
`define SHA2_REG_SEL_LSB 2
`define SHA2_REG_SEL_MSB 4

`endif

// ==== design/sha2_pkg.sv ====
// ----------------------------------------------------------------------
// SHA-2 accelerator package
// Word, block and digest types, mode and register enums, and the
// layouts of the two control registers
// ----------------------------------------------------------------------
`default_nettype none

package sha2_pkg;

    typedef logic [31:0]  sha2_word_t;
    typedef logic [63:0]  sha2_dword_t;   // Earlier word in [63:32]
    typedef logic [511:0] sha2_block_t;   // Word 0 in [511:480]
    typedef logic [255:0] sha2_digest_t;  // H0 in [255:224]

    typedef enum logic [1:0] {
        SHA256 = 2'd0,
        SHA224 = 2'd1
    } sha2_mode_e;

    typedef enum logic [2:0] {
        CTRL_0    = 3'd0,
        CTRL_1    = 3'd1,
        DATA_I_LO = 3'd2,
        DATA_I_HI = 3'd3,
        DATA_O_LO = 3'd4,
        DATA_O_HI = 3'd5,
        RSVD_0    = 3'd6,
        RSVD_1    = 3'd7
    } sha2_reg_e;

    typedef struct packed {
        logic        intr_done;
        logic        intr_next;
        logic [28:0] rsvd;
        logic        rst_n;   // Stream runs when set
    } sha2_ctrl_0_t;

    typedef struct packed {
        logic        done;
        logic        next;
        logic [25:0] rsvd;
        logic        read;    // Pop request
        sha2_mode_e  mode;
        logic        last;
    } sha2_ctrl_1_t;

    typedef struct packed {
        sha2_dword_t data;
        logic        last;
        sha2_mode_e  mode;
    } sha2_in_t;

    // Right rotate, always called with a constant amount
    function automatic sha2_word_t sha2_rotr(input sha2_word_t x, input int unsigned n);
        return (x >> n) | (x << (32 - n));
    endfunction

endpackage

`default_nettype wire

// ==== design/sha2_msg_sched.sv ====
// ----------------------------------------------------------------------
// SHA-2 message schedule
// Sliding 16-word window that presents W0..W63, one word per advance
// ----------------------------------------------------------------------
`default_nettype none

module sha2_msg_sched (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  load_i,
    input  wire sha2_pkg::sha2_block_t block_i,
    input  wire logic                  advance_i,
    output sha2_pkg::sha2_word_t       w_o
);
    import sha2_pkg::*;

    sha2_word_t win_q [16];
    sha2_word_t w_next;

    function automatic sha2_word_t ssig0(input sha2_word_t x);
        return sha2_rotr(x, 7) ^ sha2_rotr(x, 18) ^ (x >> 3);
    endfunction

    function automatic sha2_word_t ssig1(input sha2_word_t x);
        return sha2_rotr(x, 17) ^ sha2_rotr(x, 19) ^ (x >> 10);
    endfunction

    // W[t] from W[t-2], W[t-7], W[t-15] and W[t-16]
    assign w_next = ssig1(win_q[14]) + win_q[9] + ssig0(win_q[1]) + win_q[0];

    assign w_o = win_q[0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 16; i++) begin
                win_q[i] <= '0;
            end
        end else if (load_i) begin
            for (int i = 0; i < 16; i++) begin
                win_q[i] <= block_i[511 - 32*i -: 32];  // Word 0 on top
            end
        end else if (advance_i) begin
            for (int i = 0; i < 15; i++) begin
                win_q[i] <= win_q[i+1];
            end
            win_q[15] <= w_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/sha2_round_core.sv ====
// ----------------------------------------------------------------------
// SHA-2 compression core
// Iterative 64-round SHA-256/224 compression of one block per start,
// chaining the digest across the blocks of a message
// ----------------------------------------------------------------------
`default_nettype none

module sha2_round_core (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  start_i,
    input  wire logic                  first_i,
    input  wire sha2_pkg::sha2_mode_e  mode_i,
    input  wire sha2_pkg::sha2_block_t block_i,
    output logic                       busy_o,
    output logic                       done_o,
    output sha2_pkg::sha2_digest_t     digest_o
);
    import sha2_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        ROUND,
        ADD
    } state_e;

    localparam sha2_digest_t IV_256 = {
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    localparam sha2_digest_t IV_224 = {
        32'hc1059ed8, 32'h367cd507, 32'h3070dd17, 32'hf70e5939,
        32'hffc00b31, 32'h68581511, 32'h64f98fa7, 32'hbefa4fa4
    };

    localparam sha2_word_t K_TAB [64] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
        32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
        32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
        32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
        32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
        32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    state_e       state_q;
    logic [5:0]   round_q;
    sha2_digest_t chain_q;
    sha2_word_t   wv_q [8];  // Working variables a..h
    sha2_word_t   w;
    sha2_word_t   t1;
    sha2_word_t   t2;
    logic         load;

    function automatic sha2_word_t bsig0(input sha2_word_t x);
        return sha2_rotr(x, 2) ^ sha2_rotr(x, 13) ^ sha2_rotr(x, 22);
    endfunction

    function automatic sha2_word_t bsig1(input sha2_word_t x);
        return sha2_rotr(x, 6) ^ sha2_rotr(x, 11) ^ sha2_rotr(x, 25);
    endfunction

    assign busy_o = (state_q != IDLE);
    assign done_o = (state_q == ADD);
    assign load   = start_i && (state_q == IDLE);

    sha2_msg_sched sha2_msg_sched_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .load_i    (load),
        .block_i   (block_i),
        .advance_i (state_q == ROUND),
        .w_o       (w)
    );

    always_comb begin
        t1 = wv_q[7] + bsig1(wv_q[4]) + ((wv_q[4] & wv_q[5]) ^ (~wv_q[4] & wv_q[6]))
           + K_TAB[round_q] + w;
        t2 = bsig0(wv_q[0]) + ((wv_q[0] & wv_q[1]) ^ (wv_q[0] & wv_q[2]) ^ (wv_q[1] & wv_q[2]));
    end

    // Feed-forward sum, valid while done_o is high
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            digest_o[255 - 32*i -: 32] = chain_q[255 - 32*i -: 32] + wv_q[i];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            round_q <= '0;
        end else begin
            case (state_q)
                IDLE:    if (start_i) state_q <= LOAD;
                LOAD:    state_q <= ROUND;
                ROUND: begin
                    round_q <= round_q + 6'd1;
                    if (round_q == 6'd63) state_q <= ADD;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_q)
            IDLE: begin
                if (load && first_i) begin
                    chain_q <= (mode_i == SHA224) ? IV_224 : IV_256;
                end
            end
            LOAD: begin
                for (int i = 0; i < 8; i++) begin
                    wv_q[i] <= chain_q[255 - 32*i -: 32];
                end
            end
            ROUND: begin
                wv_q[0] <= t1 + t2;
                wv_q[1] <= wv_q[0];
                wv_q[2] <= wv_q[1];
                wv_q[3] <= wv_q[2];
                wv_q[4] <= wv_q[3] + t1;
                wv_q[5] <= wv_q[4];
                wv_q[6] <= wv_q[5];
                wv_q[7] <= wv_q[6];
            end
            default: chain_q <= digest_o;  // Chain into the next block
        endcase
    end

    // Stream must wait for idle before the next block
    assert property (@(posedge clk_i) disable iff (!rst_n_i) start_i |-> !busy_o)
        else $error("start while core busy");

endmodule

`default_nettype wire

// ==== design/sha2_stream.sv ====
// ----------------------------------------------------------------------
// SHA-2 stream adapter
// Packs 64-bit words into blocks for the core and returns the final
// digest as four 64-bit words
// ----------------------------------------------------------------------
`default_nettype none

module sha2_stream (
    input  wire logic               clk_i,
    input  wire logic               rst_n_i,
    input  wire sha2_pkg::sha2_in_t in_i,
    input  wire logic               in_valid_i,
    output logic                    in_ready_o,
    output sha2_pkg::sha2_dword_t   out_data_o,
    output logic                    out_valid_o,
    input  wire logic               out_ready_i
);
    import sha2_pkg::*;

    sha2_block_t  blk_q;
    logic [2:0]   cnt_q;
    logic         full_q;
    logic         start_q;
    logic         first_q;     // Next block opens a message
    logic         blk_last_q;
    sha2_mode_e   blk_mode_q;
    logic         core_busy;
    logic         core_done;
    sha2_digest_t core_digest;
    sha2_digest_t out_sr_q;
    logic [2:0]   out_cnt_q;
    logic         in_fire;
    logic         out_fire;
    logic         dig_load;

    assign in_ready_o  = !full_q && !core_busy && (out_cnt_q == 3'd0);
    assign in_fire     = in_valid_i && in_ready_o;
    assign out_valid_o = (out_cnt_q != 3'd0);
    assign out_fire    = out_ready_i && out_valid_o;
    assign out_data_o  = out_sr_q[255:192];
    assign dig_load    = core_done && blk_last_q;

    sha2_round_core sha2_round_core_inst (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .start_i  (start_q),
        .first_i  (first_q),
        .mode_i   (blk_mode_q),
        .block_i  (blk_q),
        .busy_o   (core_busy),
        .done_o   (core_done),
        .digest_o (core_digest)
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q      <= '0;
            full_q     <= 1'b0;
            start_q    <= 1'b0;
            first_q    <= 1'b1;
            blk_last_q <= 1'b0;
            blk_mode_q <= SHA256;
            out_cnt_q  <= '0;
        end else begin
            start_q <= 1'b0;
            if (in_fire) begin
                cnt_q <= cnt_q + 3'd1;  // Wraps after eight words
                if (cnt_q == 3'd7) begin
                    full_q     <= 1'b1;
                    start_q    <= 1'b1;
                    blk_last_q <= in_i.last;
                    blk_mode_q <= in_i.mode;
                end
            end
            if (start_q) begin
                full_q  <= 1'b0;
                first_q <= blk_last_q;
            end
            if (dig_load) begin
                out_cnt_q <= 3'd4;
            end else if (out_fire) begin
                out_cnt_q <= out_cnt_q - 3'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_fire) begin
            blk_q <= {blk_q[447:0], in_i.data};
        end
        if (dig_load) begin
            // SHA-224 truncates H7
            out_sr_q <= {core_digest[255:32],
                         (blk_mode_q == SHA224) ? 32'h0 : core_digest[31:0]};
        end else if (out_fire) begin
            out_sr_q <= {out_sr_q[191:0], 64'h0};
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) out_ready_i |-> out_valid_o)
        else $error("pop with no digest word pending");

endmodule

`default_nettype wire

// ==== design/sha2_mmio.sv ====
// ----------------------------------------------------------------------
// SHA-2 accelerator top level
// Register file with single-cycle strobes, push/pop to the stream,
// sticky interrupts and the soft reset of the datapath
// ----------------------------------------------------------------------
`default_nettype none

`include "sha2_config.svh"

module sha2_mmio (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,
    input  wire logic                    wr_en_i,
    input  wire logic [`SHA2_ADDR_W-1:0] wr_addr_i,
    input  wire logic [`SHA2_DATA_W-1:0] wr_data_i,
    input  wire logic                    rd_en_i,
    input  wire logic [`SHA2_ADDR_W-1:0] rd_addr_i,
    output logic      [`SHA2_DATA_W-1:0] rd_data_o,
    output logic      [1:0]              irq_o
);
    import sha2_pkg::*;

    sha2_reg_e               wr_sel;
    sha2_reg_e               rd_sel;
    sha2_ctrl_0_t            wr_ctrl_0;
    sha2_ctrl_1_t            wr_ctrl_1;
    sha2_ctrl_0_t            ctrl_0;
    sha2_ctrl_1_t            ctrl_1;
    sha2_word_t              data_i_lo_q;
    sha2_word_t              data_i_hi_q;
    logic                    last_q;
    sha2_mode_e              mode_q;
    logic                    pop_q;
    logic                    soft_rst_n_q;
    logic                    intr_done_q;
    logic                    intr_next_q;
    logic                    next_d_q;
    logic                    done_d_q;
    logic                    rd_clr;
    logic                    stream_rst_n;
    sha2_in_t                in_pkt;
    logic                    in_valid_q;
    logic                    in_ready;
    sha2_dword_t             out_data;
    logic                    out_valid;
    logic [`SHA2_DATA_W-1:0] rd_mux;

    assign wr_sel    = sha2_reg_e'(wr_addr_i[`SHA2_REG_SEL_MSB:`SHA2_REG_SEL_LSB]);
    assign rd_sel    = sha2_reg_e'(rd_addr_i[`SHA2_REG_SEL_MSB:`SHA2_REG_SEL_LSB]);
    assign wr_ctrl_0 = sha2_ctrl_0_t'(wr_data_i);
    assign wr_ctrl_1 = sha2_ctrl_1_t'(wr_data_i);
    assign rd_clr    = rd_en_i && (rd_sel == CTRL_0);

    assign stream_rst_n = rst_n_i & soft_rst_n_q;
    assign irq_o        = {intr_done_q, intr_next_q};

    assign in_pkt.data = {data_i_lo_q, data_i_hi_q};  // LO holds the earlier word
    assign in_pkt.last = last_q;
    assign in_pkt.mode = mode_q;

    always_comb begin
        ctrl_0           = '0;
        ctrl_0.intr_done = intr_done_q;
        ctrl_0.intr_next = intr_next_q;
        ctrl_0.rst_n     = soft_rst_n_q;
        ctrl_1           = '0;
        ctrl_1.done      = out_valid;
        ctrl_1.next      = in_ready;
        ctrl_1.read      = pop_q;
        ctrl_1.mode      = mode_q;
        ctrl_1.last      = last_q;
    end

    always_comb begin
        case (rd_sel)
            CTRL_0:    rd_mux = ctrl_0;
            CTRL_1:    rd_mux = ctrl_1;
            DATA_I_LO: rd_mux = data_i_lo_q;
            DATA_I_HI: rd_mux = data_i_hi_q;
            DATA_O_LO: rd_mux = out_data[31:0];
            DATA_O_HI: rd_mux = out_data[63:32];
            default:   rd_mux = '0;
        endcase
    end

    sha2_stream sha2_stream_inst (
        .clk_i       (clk_i),
        .rst_n_i     (stream_rst_n),
        .in_i        (in_pkt),
        .in_valid_i  (in_valid_q),
        .in_ready_o  (in_ready),
        .out_data_o  (out_data),
        .out_valid_o (out_valid),
        .out_ready_i (pop_q)
    );

    always_ff @(posedge clk_i) begin
        if (wr_en_i && (wr_sel == DATA_I_LO)) data_i_lo_q <= wr_data_i;
        if (wr_en_i && (wr_sel == DATA_I_HI)) data_i_hi_q <= wr_data_i;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_data_o    <= '0;
            in_valid_q   <= 1'b0;
            pop_q        <= 1'b0;
            last_q       <= 1'b0;
            mode_q       <= SHA256;
            soft_rst_n_q <= 1'b0;
            intr_done_q  <= 1'b0;
            intr_next_q  <= 1'b0;
            next_d_q     <= 1'b1;  // Ready out of reset is no edge
            done_d_q     <= 1'b0;
        end else begin
            in_valid_q <= wr_en_i && (wr_sel == DATA_I_HI);
            pop_q      <= wr_en_i && (wr_sel == CTRL_1) && wr_ctrl_1.read && out_valid;
            if (wr_en_i && (wr_sel == CTRL_0)) begin
                soft_rst_n_q <= wr_ctrl_0.rst_n;
            end
            if (wr_en_i && (wr_sel == CTRL_1)) begin
                last_q <= wr_ctrl_1.last;
                mode_q <= wr_ctrl_1.mode;
            end
            if (rd_en_i) begin
                rd_data_o <= rd_mux;
            end
            next_d_q <= in_ready;
            done_d_q <= out_valid;
            // New edge wins over the read clear
            if (in_ready && !next_d_q) begin
                intr_next_q <= 1'b1;
            end else if (rd_clr) begin
                intr_next_q <= 1'b0;
            end
            if (out_valid && !done_d_q) begin
                intr_done_q <= 1'b1;
            end else if (rd_clr) begin
                intr_done_q <= 1'b0;
            end
        end
    end

    // Host must poll next before each push
    assert property (@(posedge clk_i) disable iff (!rst_n_i) in_valid_q |-> in_ready)
        else $error("push dropped, stream not ready");

endmodule

`default_nettype wire

// ==== sim/tb_sha2.sv ====
// ----------------------------------------------------------------------
// SHA-2 accelerator testbench
// Plays padded messages from the input file through the register port
// and checks the popped digests, interrupts and soft reset
// ----------------------------------------------------------------------
`default_nettype none

`include "sha2_config.svh"

module tb_sha2;
    timeunit 1ns;
    timeprecision 1ps;

    import sha2_pkg::*;

    localparam int MAX_REC    = 8;
    localparam int REC_WORDS  = 32;   // Two blocks of 16 words
    localparam int POLL_LIMIT = 100;

    typedef logic [8*160-1:0] line_t;

    logic                    clk;
    logic                    rst_n;
    logic                    wr_en;
    logic [`SHA2_ADDR_W-1:0] wr_addr;
    logic [`SHA2_DATA_W-1:0] wr_data;
    logic                    rd_en;
    logic [`SHA2_ADDR_W-1:0] rd_addr;
    logic [`SHA2_DATA_W-1:0] rd_data;
    logic [1:0]              irq;

    int          fd;
    int          n_rec;
    int          rec_mode   [MAX_REC];
    int          rec_blocks [MAX_REC];
    logic [31:0] msg_words  [MAX_REC*REC_WORDS];
    logic [31:0] exp_digest [MAX_REC*8];
    logic [31:0] row        [8];

    sha2_mmio sha2_mmio_inst (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data),
        .irq_o     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    function automatic logic [`SHA2_ADDR_W-1:0] reg_addr(input sha2_reg_e r);
        logic [`SHA2_ADDR_W-1:0] a;
        a = '0;
        a[`SHA2_REG_SEL_MSB:`SHA2_REG_SEL_LSB] = r;
        return a;
    endfunction

    task automatic write_reg(input sha2_reg_e r, input logic [31:0] data);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_addr <= reg_addr(r);
        wr_data <= data;
        @(posedge clk);
        wr_en   <= 1'b0;
    endtask

    // Read data settles on the edge after the strobe
    task automatic read_reg(input sha2_reg_e r, output logic [31:0] data);
        @(posedge clk);
        rd_en   <= 1'b1;
        rd_addr <= reg_addr(r);
        @(posedge clk);
        rd_en   <= 1'b0;
        @(negedge clk);
        data = rd_data;
    endtask

    task automatic wait_ctrl_1(input int bit_idx, input string what);
        logic [31:0] val;
        int          tries;
        tries = 0;
        read_reg(CTRL_1, val);
        while (!val[bit_idx]) begin
            tries++;
            if (tries > POLL_LIMIT) begin
                stop_with_error($sformatf("Timed out waiting for CTRL_1 %s", what));
            end
            read_reg(CTRL_1, val);
        end
    endtask

    task automatic next_line(output line_t line, output bit found);
        int  n;
        byte ch;
        found = 1'b0;
        while (!found && !$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, " %c", ch) == 1 && ch != "#") begin
                found = 1'b1;   // Skip blanks and comments
            end
        end
    endtask

    task automatic read_row();
        line_t line;
        bit    found;
        next_line(line, found);
        if (!found || $sscanf(line, "%h %h %h %h %h %h %h %h", row[0], row[1], row[2],
                              row[3], row[4], row[5], row[6], row[7]) != 8) begin
            stop_with_error("Input file has a short or missing data line");
        end
    endtask

    task automatic load_records();
        line_t line;
        bit    found;
        int    mode;
        int    nb;
        fd = $fopen("sim/tb_sha2_input.txt", "r");
        if (fd == 0) stop_with_error("Cannot open sim/tb_sha2_input.txt");
        n_rec = 0;
        next_line(line, found);
        while (found) begin
            if (n_rec >= MAX_REC || $sscanf(line, "%d %d", mode, nb) != 2
                || nb < 1 || nb > 2) begin
                stop_with_error("Input file has a bad record header");
            end
            rec_mode[n_rec]   = mode;
            rec_blocks[n_rec] = nb;
            for (int i = 0; i < 2*nb; i++) begin
                read_row();
                for (int j = 0; j < 8; j++) msg_words[n_rec*REC_WORDS + 8*i + j] = row[j];
            end
            read_row();
            for (int j = 0; j < 8; j++) exp_digest[n_rec*8 + j] = row[j];
            n_rec++;
            next_line(line, found);
        end
        $fclose(fd);
    endtask

    // LO carries the earlier message word
    task automatic push_word(input logic [31:0] first, input logic [31:0] second);
        wait_ctrl_1(30, "next");
        write_reg(DATA_I_LO, first);
        write_reg(DATA_I_HI, second);
    endtask

    task automatic push_message(input int rec);
        sha2_ctrl_1_t ctrl;
        int           base;
        for (int b = 0; b < rec_blocks[rec]; b++) begin
            ctrl      = '0;
            ctrl.mode = sha2_mode_e'(rec_mode[rec]);
            ctrl.last = (b == rec_blocks[rec] - 1);
            write_reg(CTRL_1, ctrl);
            for (int k = 0; k < 8; k++) begin
                base = rec*REC_WORDS + b*16 + 2*k;
                push_word(msg_words[base], msg_words[base+1]);
            end
        end
    endtask

    task automatic pop_digest(input int rec);
        logic [31:0] val;
        wait_ctrl_1(31, "done");
        for (int i = 0; i < 4; i++) begin
            read_reg(DATA_O_HI, val);
            check($sformatf("DATA_O_HI rec %0d pop %0d", rec, i), val, exp_digest[rec*8 + 2*i]);
            read_reg(DATA_O_LO, val);
            check($sformatf("DATA_O_LO rec %0d pop %0d", rec, i), val, exp_digest[rec*8 + 2*i + 1]);
            if (rec_mode[rec] == 1 && i == 3) check("DATA_O_LO SHA-224 H7", val, 32'h0);
            write_reg(CTRL_1, 32'h8);   // Read bit pops one word
        end
        read_reg(CTRL_1, val);
        check("CTRL_1.done after pops", val[31], 1'b0);
    endtask

    initial begin
        logic [31:0] val;
        rst_n   = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_en   = 1'b0;
        rd_addr = '0;
        load_records();
        if (n_rec < 4) stop_with_error("Input file holds fewer than four records");
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        read_reg(CTRL_0, val);
        check("CTRL_0 after reset", val, 32'h0);
        check("irq_o after reset", irq, 2'b00);
        write_reg(CTRL_0, 32'h1);
        read_reg(CTRL_1, val);
        check("CTRL_1.next", val[30], 1'b1);
        check("CTRL_1.done", val[31], 1'b0);

        // File order covers chaining and then a fresh IV
        for (int r = 0; r < n_rec; r++) begin
            push_message(r);
            pop_digest(r);
        end

        read_reg(CTRL_0, val);                  // Clears sticky bits
        check("irq_o done before message", irq[1], 1'b0);
        push_message(0);
        wait_ctrl_1(31, "done");
        check("irq_o done", irq[1], 1'b1);
        read_reg(CTRL_0, val);
        check("CTRL_0.intr_done", val[31], 1'b1);
        check("irq_o done after CTRL_0 read", irq[1], 1'b0);
        check("irq_o next after CTRL_0 read", irq[0], 1'b0);
        pop_digest(0);
        check("irq_o next after pops", irq[0], 1'b1);   // Ready rises once the digest drains

        // Partial block dropped by the soft reset
        write_reg(CTRL_1, 32'h0);
        for (int k = 0; k < 3; k++) push_word(32'hdead0000 + k, 32'hbeef0000 + k);
        write_reg(CTRL_0, 32'h0);
        write_reg(CTRL_0, 32'h1);
        read_reg(CTRL_0, val);
        check("CTRL_0.rst_n", val[0], 1'b1);
        push_message(1);
        pop_digest(1);

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_sha2_input.txt ====
# mode (0 SHA-256, 1 SHA-224) and block count, then two lines of eight
# message words per block, then one line of eight expected digest words, hex
# abc, SHA-256
0 1
61626380 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000018
ba7816bf 8f01cfea 414140de 5dae2223 b00361a3 96177a9c b410ff61 f20015ad
# abc, SHA-224
1 1
61626380 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000018
23097d22 3405d822 8642a477 bda255b3 2aadbce4 bda0b3f7 e36c9da7 00000000
# 448-bit two-block message, SHA-256
0 2
61626364 62636465 63646566 64656667 65666768 66676869 6768696a 68696a6b
696a6b6c 6a6b6c6d 6b6c6d6e 6c6d6e6f 6d6e6f70 6e6f7071 80000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 000001c0
248d6a61 d20638b8 e5c02693 0c3e6039 a33ce459 64ff2167 f6ecedd4 19db06c1
# empty message, SHA-256
0 1
80000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
e3b0c442 98fc1c14 9afbf4c8 996fb924 27ae41e4 649b934c a495991b 7852b855

// ==== all.f ====
+incdir+include
design/sha2_pkg.sv
design/sha2_msg_sched.sv
design/sha2_round_core.sv
design/sha2_stream.sv
design/sha2_mmio.sv
sim/tb_sha2.sv
